// ==== design/cpu_core.sv ====
/* Five-stage pipelined 16-bit core
   PC, stage registers, forwarding muxes, halt freeze and write-back select */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import isa_pkg::*, pipe_pkg::*; #(
    parameter int dmem_words = 256
) (
    input  logic    clk,
    input  logic    reset,
    output word_t   inst_addr,
    input  word_t   inst,
    output logic    hlt,
    output retire_t wb
);

    word_t     pc;
    logic      if_id_valid;
    instr_u    if_id_instr;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    logic      halt_seen;                       // HLT has left ID
    ctrl_t     dec_ctrl;
    reg_addr_t dec_rd;
    reg_addr_t dec_src1;
    reg_addr_t dec_src2;
    logic      dec_reads_src2;
    word_t     dec_imm;
    word_t     rf_data1;
    word_t     rf_data2;
    logic      stall;
    logic      id_halt;
    logic      fetch_hold;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    fwd_sel_t  fwd_store;
    word_t     ex_a;
    word_t     ex_src2_val;
    word_t     ex_b;
    word_t     ex_result;
    word_t     store_data;
    word_t     dmem_rdata;

    function automatic word_t fwd_pick(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        word_t v;
        case (sel)
            fwd_mem: v = mem_val;
            fwd_wb:  v = wb_val;
            default: v = reg_val;
        endcase
        return v;
    endfunction

    // Fetch
    assign inst_addr  = pc;
    assign id_halt    = if_id_valid && dec_ctrl.halt;
    assign fetch_hold = halt_seen || id_halt;   // Nothing past HLT enters

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall && !fetch_hold) begin
            pc <= pc + word_t'(2);              // Byte address, two per word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_id_valid <= 1'b0;
            if_id_instr <= '0;                  // Bubble word decodes to nothing
            halt_seen   <= 1'b0;
        end else begin
            if (id_halt)
                halt_seen <= 1'b1;
            if (!stall) begin
                if_id_valid <= !fetch_hold;
                if_id_instr <= fetch_hold ? '0 : inst;
            end
        end
    end

    // Decode
    decode_unit u_decode (
        .instr      (if_id_instr),
        .ctrl       (dec_ctrl),
        .rd         (dec_rd),
        .src1       (dec_src1),
        .src2       (dec_src2),
        .reads_src2 (dec_reads_src2),
        .imm        (dec_imm)
    );

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (dec_src1),
        .rd_addr2 (dec_src2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2),
        .wr       (wb)
    );

    hazard_unit u_hazard (
        .id_src1       (dec_src1),
        .id_src2       (dec_src2),
        .id_reads_src2 (dec_reads_src2),
        .ex_rd         (id_ex.rd),
        .ex_mem_rd     (id_ex.valid && id_ex.ctrl.mem_rd),
        .mem_rd        (ex_mem.rd),
        .mem_reg_we    (ex_mem.valid && ex_mem.ctrl.reg_we),
        .wb_rd         (mem_wb.rd),
        .wb_reg_we     (wb.we),
        .ex_src1       (id_ex.src1),
        .ex_src2       (id_ex.src2),
        .mem_src2      (ex_mem.src2),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd_store     (fwd_store)
    );

    always_ff @(posedge clk) begin
        if (reset || stall || !if_id_valid) begin
            id_ex.valid <= 1'b0;                // Bubble
            id_ex.ctrl  <= '0;
        end else begin
            id_ex <= '{valid: 1'b1, ctrl: dec_ctrl, op: if_id_instr.r.op, rd: dec_rd,
                       src1: dec_src1, src2: dec_src2, a: rf_data1, b: rf_data2,
                       imm: dec_imm};
        end
    end

    // Execute
    assign ex_a        = fwd_pick(fwd_a, id_ex.a, ex_mem.alu_res, wb.data);
    assign ex_src2_val = fwd_pick(fwd_b, id_ex.b, ex_mem.alu_res, wb.data);
    assign ex_b        = id_ex.ctrl.use_imm ? id_ex.imm : ex_src2_val;

    execute_alu u_alu (
        .op     (id_ex.op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem <= '{valid: id_ex.valid, ctrl: id_ex.ctrl, rd: id_ex.rd, src2: id_ex.src2,
                        alu_res: ex_result, st_data: ex_src2_val};
        end
    end

    // Memory, a just-loaded value reaches store data here
    assign store_data = fwd_pick(fwd_store, ex_mem.st_data, ex_mem.alu_res, wb.data);

    data_memory #(
        .words (dmem_words)
    ) u_dmem (
        .clk   (clk),
        .reset (reset),
        .addr  (ex_mem.alu_res),
        .wdata (store_data),
        .we    (ex_mem.valid && ex_mem.ctrl.mem_we),
        .rdata (dmem_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
            mem_wb.ctrl  <= '0;
            hlt          <= 1'b0;
        end else begin
            mem_wb <= '{valid: ex_mem.valid, ctrl: ex_mem.ctrl, rd: ex_mem.rd,
                        alu_res: ex_mem.alu_res, mem_data: dmem_rdata};
            if (ex_mem.valid && ex_mem.ctrl.halt)
                hlt <= 1'b1;                    // Sticky until reset
        end
    end

    // Write-back
    always_comb begin
        wb.we   = mem_wb.valid && mem_wb.ctrl.reg_we && (mem_wb.rd != '0);
        wb.dst  = mem_wb.rd;
        wb.data = mem_wb.ctrl.wb_from_mem ? mem_wb.mem_data : mem_wb.alu_res;
    end

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
/* Data RAM
   Combinational read, write on the rising edge, indexed by low address bits */
`timescale 1ns/1ps
`default_nettype none

module data_memory import isa_pkg::*; #(
    parameter int words = 256                   // Power of two
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata
);

    localparam int aw = $clog2(words);

    word_t           mem [words];
    logic [aw-1:0]   idx;                       // Upper address bits ignored

    assign idx   = addr[aw-1:0];
    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < words; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
/* Instruction decoder
   Produces control, register selects and the extended immediate for ID */
`timescale 1ns/1ps
`default_nettype none

module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  instr_u    instr,
    output ctrl_t     ctrl,
    output reg_addr_t rd,
    output reg_addr_t src1,
    output reg_addr_t src2,
    output logic      reads_src2,
    output word_t     imm
);

    word_t off_sext;                            // Memory offset, signed
    word_t nib_raw;                             // Shift amount, unsigned
    word_t byte_raw;                            // Byte for LLB/LHB

    assign rd       = instr.r.rd;
    assign off_sext = {{(data_w-4){instr.r.lo[3]}}, instr.r.lo};
    assign nib_raw  = {{(data_w-4){1'b0}}, instr.r.lo};
    assign byte_raw = {{(data_w-8){1'b0}}, instr.b.imm8};

    always_comb begin
        ctrl       = '0;                        // Unknown opcodes stay a no-op
        src1       = '0;                        // Index 0 never stalls or forwards
        src2       = '0;
        reads_src2 = 1'b0;
        imm        = '0;
        case (instr.r.op)
            op_add, op_sub, op_xor: begin
                ctrl.reg_we = 1'b1;
                src1        = instr.r.rs;
                src2        = instr.r.lo;       // rt
                reads_src2  = 1'b1;
            end
            op_sll, op_sra, op_ror: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                src1         = instr.r.rs;
                imm          = nib_raw;
            end
            op_lw: begin
                ctrl.reg_we      = 1'b1;
                ctrl.use_imm     = 1'b1;
                ctrl.mem_rd      = 1'b1;
                ctrl.wb_from_mem = 1'b1;
                src1             = instr.r.rs;  // Address base
                imm              = off_sext;
            end
            op_sw: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
                src1         = instr.r.rs;      // Address base
                src2         = instr.r.rd;      // Store data, not an ALU operand
                imm          = off_sext;
            end
            op_llb, op_lhb: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                src1         = instr.b.rd;      // Other byte of rd is kept
                imm          = byte_raw;
            end
            op_hlt: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/execute_alu.sv ====
/* EX stage ALU
   Arithmetic, shifts, byte-load merge and memory address generation */
`timescale 1ns/1ps
`default_nettype none

module execute_alu import isa_pkg::*; (
    input  opcode_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [3:0]          shamt;                 // Shift amount from imm
    logic [2*data_w-1:0] rot;                   // Doubled word for rotate

    assign shamt = b[3:0];
    assign rot   = {a, a} >> shamt;

    always_comb begin
        case (op)
            op_add:  result = a + b;            // Wraps
            op_sub:  result = a - b;
            op_xor:  result = a ^ b;
            op_sll:  result = a << shamt;
            op_sra:  result = word_t'($signed(a) >>> shamt);
            op_ror:  result = rot[data_w-1:0];
            op_llb:  result = {a[data_w-1:8], b[7:0]};
            op_lhb:  result = {b[7:0], a[7:0]};
            op_lw,
            op_sw:   result = a + b;            // Base plus signed offset
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
/* Hazard detection
   Load-to-use stall and forwarding selects for EX operands and MEM store data */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t id_src1,
    input  reg_addr_t id_src2,
    input  logic      id_reads_src2,
    input  reg_addr_t ex_rd,
    input  logic      ex_mem_rd,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_we,
    input  reg_addr_t wb_rd,
    input  logic      wb_reg_we,
    input  reg_addr_t ex_src1,
    input  reg_addr_t ex_src2,
    input  reg_addr_t mem_src2,
    output logic      stall,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output fwd_sel_t  fwd_store
);

    logic mem_live;                             // EX/MEM holds a usable result
    logic wb_live;                              // MEM/WB holds a usable result

    assign mem_live = mem_reg_we && (mem_rd != '0);
    assign wb_live  = wb_reg_we && (wb_rd != '0);

    // Store data from a load is fixed up in MEM, so SW data does not stall
    assign stall = ex_mem_rd && (ex_rd != '0) &&
                   ((ex_rd == id_src1) || (id_reads_src2 && ex_rd == id_src2));

    // Younger result wins
    always_comb begin
        if (mem_live && mem_rd == ex_src1)     fwd_a = fwd_mem;
        else if (wb_live && wb_rd == ex_src1)  fwd_a = fwd_wb;
        else                                   fwd_a = fwd_none;

        if (mem_live && mem_rd == ex_src2)     fwd_b = fwd_mem;
        else if (wb_live && wb_rd == ex_src2)  fwd_b = fwd_wb;
        else                                   fwd_b = fwd_none;

        fwd_store = (wb_live && wb_rd == mem_src2) ? fwd_wb : fwd_none;
    end

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
/* Instruction set of the 16-bit load/store core
   Opcode encodings, field types and the two decodings of one instruction word */
`default_nettype none

package isa_pkg;

    localparam int data_w = 16;                 // Data and address width

    typedef logic [3:0]        reg_addr_t;      // One of sixteen registers
    typedef logic [data_w-1:0] word_t;          // Data word

    typedef enum logic [3:0] {
        op_add = 4'h0,                          // rd = rs + rt
        op_sub = 4'h1,                          // rd = rs - rt
        op_xor = 4'h2,                          // rd = rs ^ rt
        op_sll = 4'h4,                          // Shift left by imm
        op_sra = 4'h5,                          // Arithmetic shift right by imm
        op_ror = 4'h6,                          // Rotate right by imm
        op_lw  = 4'h8,                          // rd = mem[rs + offset]
        op_sw  = 4'h9,                          // mem[rs + offset] = rd
        op_llb = 4'hA,                          // Load low byte of rd
        op_lhb = 4'hB,                          // Load high byte of rd
        op_hlt = 4'hF                           // Stop fetching
    } opcode_t;

    // Register form, used by ALU ops, shifts and memory ops
    typedef struct packed {
        opcode_t    op;
        reg_addr_t  rd;
        reg_addr_t  rs;
        logic [3:0] lo;                         // rt, shift amount or offset
    } instr_r_t;

    // Byte form, used by LLB and LHB
    typedef struct packed {
        opcode_t    op;
        reg_addr_t  rd;
        logic [7:0] imm8;                       // Byte to insert
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_b_t b;
    } instr_u;

endpackage

`default_nettype wire

// ==== design/pipe_pkg.sv ====
/* Pipeline bundles of the core
   Control word, stage register layouts, retire record and forwarding selects */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic reg_we;                           // Writes rd at retire
        logic use_imm;                          // Operand b from immediate
        logic mem_rd;                           // Load
        logic mem_we;                           // Store
        logic wb_from_mem;                      // Retire memory data, not ALU result
        logic halt;                             // HLT marker
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t src1;                        // Index behind operand a
        reg_addr_t src2;                        // Index behind operand b or store data
        word_t     a;                           // Register value read in ID
        word_t     b;
        word_t     imm;                         // Extended immediate
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rd;
        reg_addr_t src2;                        // Store data source, for MEM forward
        word_t     alu_res;                     // Result or memory address
        word_t     st_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     mem_data;
    } mem_wb_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dst;
        word_t     data;
    } retire_t;

    typedef enum logic [1:0] {
        fwd_none,                               // Value from ID read
        fwd_mem,                                // EX/MEM ALU result
        fwd_wb                                  // MEM/WB retire data
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== design/register_file.sv ====
/* Sixteen-entry register file
   Register 0 reads zero, a same-cycle write is passed through to both readers */
`timescale 1ns/1ps
`default_nettype none

module register_file import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    output word_t     rd_data1,
    output word_t     rd_data2,
    input  retire_t   wr
);

    word_t regs [16];
    logic  wr_ok;                               // Write that actually lands

    assign wr_ok = wr.we && (wr.dst != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr.dst] <= wr.data;
        end
    end

    // Write-through covers the WB to ID distance
    assign rd_data1 = (wr_ok && wr.dst == rd_addr1) ? wr.data : regs[rd_addr1];
    assign rd_data2 = (wr_ok && wr.dst == rd_addr2) ? wr.data : regs[rd_addr2];

endmodule

`default_nettype wire

// ==== filelist.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode_unit.sv
design/register_file.sv
design/execute_alu.sv
design/hazard_unit.sv
design/data_memory.sv
design/cpu_core.sv
tests/tb_clock.sv
tests/cpu_core_properties.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_core_tb -f filelist.f -o cpu_core_sim
./obj_dir/cpu_core_sim

// ==== tests/cpu_core_properties.sv ====
/* Bound checks on the core boundary
   Reset state, sticky halt, frozen fetch and retire strobe rules */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_properties import isa_pkg::*, pipe_pkg::*; (
    input logic    clk,
    input logic    reset,
    input word_t   inst_addr,
    input logic    hlt,
    input retire_t wb
);

    // Core comes out of reset fetching word 0 with nothing retiring
    reset_state: assert property (@(posedge clk) reset |=> (inst_addr == '0 && !hlt && !wb.we))
        else $error("core state is not clear one cycle after reset");

    halt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else $error("hlt dropped before reset");

    halt_pc_frozen: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(inst_addr))
        else $error("inst_addr moved after hlt");

    // Nothing behind HLT may retire
    halt_no_retire: assert property (@(posedge clk) disable iff (reset) hlt |-> !wb.we)
        else $error("writeback seen while halted");

    no_zero_write: assert property (@(posedge clk) disable iff (reset) wb.we |-> wb.dst != '0)
        else $error("writeback strobe raised for register 0");

endmodule

`default_nettype wire

// ==== tests/cpu_core_tb.sv ====
/* Testbench for the pipelined core
   Random program with a sequential reference model, retire order and value checks */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int dmem_words     = 256;
    localparam int maw            = $clog2(dmem_words);
    localparam int prog_words     = 512;
    localparam int random_slots   = 170;            // Some slots emit two instructions
    localparam int timeout_cycles = 4000;
    localparam opcode_t alu_ops   [3] = '{op_add, op_sub, op_xor};
    localparam opcode_t shift_ops [3] = '{op_sll, op_sra, op_ror};

    logic    clk;
    logic    reset;
    word_t   inst;
    word_t   inst_addr;
    logic    hlt;
    retire_t wb;

    word_t     prog  [prog_words];                  // Instruction memory image
    word_t     mregs [16];                          // Model register file
    word_t     mmem  [dmem_words];                  // Model data memory
    retire_t   expected [$];                        // Retires in program order
    integer    seed = 56447;
    int        n_instr;
    reg_addr_t last_rd;                             // Recent targets, for dependent sources
    reg_addr_t prev_rd;

    tb_clock u_clock (.clk(clk));

    cpu_core #(
        .dmem_words (dmem_words)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .inst_addr (inst_addr),
        .inst      (inst),
        .hlt       (hlt),
        .wb        (wb)
    );

    bind cpu_core cpu_core_properties u_props (
        .clk(clk), .reset(reset), .inst_addr(inst_addr), .hlt(hlt), .wb(wb)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
        abort_run("retired value differs from the model");
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t r_word(input opcode_t op, input reg_addr_t rd,
                                     input reg_addr_t rs, input logic [3:0] lo);
        return {op, rd, rs, lo};
    endfunction

    function automatic word_t b_word(input opcode_t op, input reg_addr_t rd, input logic [7:0] b);
        return {op, rd, b};
    endfunction

    function automatic reg_addr_t pick_dst();
        return reg_addr_t'(rand_below(15));         // r15 stays the memory base, r0 allowed
    endfunction

    function automatic reg_addr_t pick_src();
        if (rand_below(2) == 0)
            return rand_below(2) == 0 ? last_rd : prev_rd;  // Back-to-back dependence
        return reg_addr_t'(rand_below(16));
    endfunction

    // Sequential ISA model, one instruction at a time
    task automatic model_step(input instr_u ins);
        word_t      a;
        word_t      res;
        word_t      addr;
        logic       writes;
        logic [3:0] sh;
        a      = mregs[ins.r.rs];
        sh     = ins.r.lo;
        addr   = a + {{12{ins.r.lo[3]}}, ins.r.lo};
        writes = 1'b1;
        res    = '0;
        case (ins.r.op)
            op_add: res = a + mregs[ins.r.lo];
            op_sub: res = a - mregs[ins.r.lo];
            op_xor: res = a ^ mregs[ins.r.lo];
            op_sll: res = a << sh;
            op_sra: res = (a >> sh) | (a[15] ? ~(16'hFFFF >> sh) : 16'h0000);  // Sign fill
            op_ror: res = (a >> sh) | (a << (16 - sh));
            op_lw:  res = mmem[addr[maw-1:0]];
            op_sw: begin
                mmem[addr[maw-1:0]] = mregs[ins.r.rd];
                writes = 1'b0;
            end
            op_llb: res = {mregs[ins.b.rd][15:8], ins.b.imm8};
            op_lhb: res = {ins.b.imm8, mregs[ins.b.rd][7:0]};
            default: writes = 1'b0;                 // HLT and unused codes
        endcase
        if (writes && ins.r.rd != '0) begin
            mregs[ins.r.rd] = res;
            expected.push_back('{we: 1'b1, dst: ins.r.rd, data: res});
        end
    endtask

    task automatic emit(input instr_u ins);
        prog[n_instr] = ins;
        model_step(ins);
        n_instr++;
        if (ins.r.op != op_sw && ins.r.op != op_hlt) begin
            prev_rd = last_rd;
            last_rd = ins.r.rd;
        end
    endtask

    task automatic build_program();
        reg_addr_t   d;
        int unsigned k;
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = {op_add, 4'h8 | 4'(i >> 8), 8'(i)};  // Unused words would retire, tagged by index
        end
        for (int i = 0; i < 16; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            mmem[i] = '0;
        end
        n_instr = 0;
        last_rd = '0;
        prev_rd = '0;
        for (int r = 1; r < 15; r++) begin
            emit(b_word(op_llb, reg_addr_t'(r), 8'(rand_below(256))));
            emit(b_word(op_lhb, reg_addr_t'(r), 8'(rand_below(256))));
        end
        emit(b_word(op_llb, 4'd15, 8'h20));         // Base 0x0020, offsets stay in 16 words
        emit(b_word(op_lhb, 4'd15, 8'h00));
        for (int i = 0; i < random_slots; i++) begin
            k = rand_below(8);
            d = pick_dst();
            case (k)
                0, 1, 2: emit(r_word(alu_ops[k], d, pick_src(), pick_src()));
                3: emit(r_word(shift_ops[rand_below(3)], d, pick_src(), 4'(rand_below(16))));
                4: emit(r_word(op_lw, d, 4'd15, 4'(rand_below(16))));
                5: emit(r_word(op_sw, pick_src(), 4'd15, 4'(rand_below(16))));
                6: begin                            // Load then use, one bubble
                    emit(r_word(op_lw, d, 4'd15, 4'(rand_below(16))));
                    emit(r_word(op_add, pick_dst(), d, pick_src()));
                end
                default: begin                      // Store of a just-loaded value
                    emit(r_word(op_lw, d, 4'd15, 4'(rand_below(16))));
                    emit(r_word(op_sw, d, 4'd15, 4'(rand_below(16))));
                end
            endcase
        end
        emit(r_word(op_hlt, 4'd0, 4'd0, 4'd0));
    endtask

    // Fetch port follows the PC, which only moves on the rising edge
    always @(inst_addr) begin
        inst <= prog[inst_addr[9:1]];
    end

    always @(posedge clk) begin
        retire_t head;
        if (!reset && wb.we) begin
            if (expected.size() == 0) begin
                abort_run("a writeback appeared with no instruction left to retire");
            end else begin
                head = expected.pop_front();
                assert (wb.dst == head.dst)
                    else report_mismatch("wb.dst", word_t'(wb.dst), word_t'(head.dst));
                assert (wb.data == head.data)
                    else report_mismatch("wb.data", wb.data, head.data);
            end
        end
    end

    initial begin
        int cycles;
        reset = 1'b1;
        inst  = '0;
        build_program();
        inst = prog[0];
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);                         // Two cycles of reset
        end
        reset <= 1'b0;
        cycles = 0;
        while (!hlt && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!hlt) begin
            abort_run("hlt did not rise before the timeout");
        end else begin
            for (int i = 0; i < 8; i++) begin
                @(posedge clk);                     // Halted core must stay quiet
            end
            if (expected.size() != 0) begin
                abort_run("core halted with model writebacks still pending");
            end else begin
                $display("TEST PASSED");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
/* Testbench clock source, free-running with a 4 ns period */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter realtime half_period = 2.0        // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

`default_nettype wire
